//--- source/fp_slice_pkg.sv
// ------------------
// Shared widths, encodings and format helpers of the SIMD slice
// Fixed to a 32-bit FLEN with FP32, FP16 and FP8 (E5M2) lanes
// ------------------
package fp_slice_pkg;

  localparam int unsigned FLEN        = 32;
  localparam int unsigned NUM_LANES   = 4;
  localparam int unsigned NUM_FORMATS = 3;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2   // E5M2
  } fp_format_e;

  typedef enum logic [1:0] {
    SGNJ   = 2'd0,
    SGNJN  = 2'd1,
    SGNJX  = 2'd2,
    MINMAX = 2'd3
  } operation_e;

  typedef logic [4:0] status_t;    // NV, DZ, OF, UF, NX
  typedef logic [3:0] tag_t;
  typedef logic [2:0] aux_t;       // {vector flag, format}
  typedef logic [2:0] fmt_mask_t;  // Bit index is the format encoding

  // --------------------
  // Format properties
  // --------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP32:    return 32;
      FP16:    return 16;
      default: return 8;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    return (fmt == FP32) ? 8 : 5;
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    case (fmt)
      FP32:    return 23;
      FP16:    return 10;
      default: return 2;
    endcase
  endfunction

  // Lane 0 serves every format, upper lanes only the narrow ones
  function automatic fmt_mask_t lane_formats(int unsigned lane);
    if (lane == 0) return 3'b111;
    if (lane == 1) return 3'b110;
    if (lane < NUM_LANES) return 3'b100;
    return 3'b000;
  endfunction

  function automatic int unsigned lane_width(fmt_mask_t formats);
    int unsigned width;
    width = 0;
    for (int unsigned f = 0; f < NUM_FORMATS; f++) begin
      if (formats[f] && (fp_width(fp_format_e'(f)) > width)) width = fp_width(fp_format_e'(f));
    end
    return width;
  endfunction

endpackage

//--- source/fp_lane_pipeline.sv
// ------------------
// Valid/ready pipeline carrying one lane result and its side data
// NumPipeRegs of 0 gives a combinational path; only valid bits reset
// ------------------
`timescale 1ns/1ps

module fp_lane_pipeline #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned DataWidth   = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [DataWidth-1:0]  result_i,
  input  fp_slice_pkg::status_t status_i,
  input  logic                  mask_i,
  input  fp_slice_pkg::tag_t    tag_i,
  input  fp_slice_pkg::aux_t    aux_i,
  output logic [DataWidth-1:0]  result_o,
  output fp_slice_pkg::status_t status_o,
  output logic                  mask_o,
  output fp_slice_pkg::tag_t    tag_o,
  output fp_slice_pkg::aux_t    aux_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  // Index i holds the item after i register stages
  logic [0:NumPipeRegs][DataWidth-1:0]   result_q;
  fp_slice_pkg::status_t [0:NumPipeRegs] status_q;
  logic [0:NumPipeRegs]                  mask_q;
  fp_slice_pkg::tag_t [0:NumPipeRegs]    tag_q;
  fp_slice_pkg::aux_t [0:NumPipeRegs]    aux_q;
  logic [0:NumPipeRegs]                  valid_q;
  logic [0:NumPipeRegs]                  ready;

  assign result_q[0] = result_i;
  assign status_q[0] = status_i;
  assign mask_q[0]   = mask_i;
  assign tag_q[0]    = tag_i;
  assign aux_q[0]    = aux_i;
  assign valid_q[0]  = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_en;

    assign ready[i] = ready[i+1] | ~valid_q[i+1];  // Next stage takes it or is a bubble
    assign reg_en   = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        mask_q[i+1]   <= mask_q[i];
        tag_q[i+1]    <= tag_q[i];
        aux_q[i+1]    <= aux_q[i];
      end
    end
  end

  assign ready[NumPipeRegs] = out_ready_i;  // Driven from downstream
  assign in_ready_o         = ready[0];

  assign result_o    = result_q[NumPipeRegs];
  assign status_o    = status_q[NumPipeRegs];
  assign mask_o      = mask_q[NumPipeRegs];
  assign tag_o       = tag_q[NumPipeRegs];
  assign aux_o       = aux_q[NumPipeRegs];
  assign out_valid_o = valid_q[NumPipeRegs];

  if (NumPipeRegs > 0) begin : gen_busy
    assign busy_o = |valid_q[1:NumPipeRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;  // Nothing is ever held
  end

  // A stalled output keeps its item until it is taken
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(status_o)
      && $stable(mask_o) && $stable(tag_o) && $stable(aux_o))
    else $error("Lane pipeline output changed while stalled");

endmodule

//--- source/fp_noncomp_lane.sv
// ------------------
// One SIMD lane for sign injection and min/max on its supported formats
// Result is zero-extended within the lane; only NV can be raised
// ------------------
`timescale 1ns/1ps

module fp_noncomp_lane #(
  parameter fp_slice_pkg::fmt_mask_t LaneFormats = 3'b111,
  parameter int unsigned NumPipeRegs = 2,
  localparam int unsigned LaneWidth = fp_slice_pkg::lane_width(LaneFormats)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [LaneWidth-1:0]     operand_a_i,
  input  logic [LaneWidth-1:0]     operand_b_i,
  input  fp_slice_pkg::operation_e op_i,
  input  logic                     op_mod_i,    // Selects max for MINMAX
  input  fp_slice_pkg::fp_format_e fmt_i,
  input  logic                     mask_i,
  input  fp_slice_pkg::tag_t       tag_i,
  input  fp_slice_pkg::aux_t       aux_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output logic [LaneWidth-1:0]     result_o,
  output fp_slice_pkg::status_t    status_o,
  output logic                     mask_o,
  output fp_slice_pkg::tag_t       tag_o,
  output fp_slice_pkg::aux_t       aux_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  logic [fp_slice_pkg::NUM_FORMATS-1:0][LaneWidth-1:0] fmt_result;
  fp_slice_pkg::status_t [fp_slice_pkg::NUM_FORMATS-1:0] fmt_status;
  logic [LaneWidth-1:0]  op_result;
  fp_slice_pkg::status_t op_status;

  // --------------------
  // Per-format datapath
  // --------------------
  for (genvar f = 0; f < fp_slice_pkg::NUM_FORMATS; f++) begin : gen_fmt
    localparam fp_slice_pkg::fp_format_e Fmt = fp_slice_pkg::fp_format_e'(f);
    localparam int unsigned FpW  = fp_slice_pkg::fp_width(Fmt);
    localparam int unsigned ExpW = fp_slice_pkg::exp_bits(Fmt);
    localparam int unsigned ManW = fp_slice_pkg::man_bits(Fmt);

    if (LaneFormats[f]) begin : gen_active
      logic           sign_a, sign_b, sign_inj;
      logic [FpW-2:0] mag_a, mag_b;
      logic           nan_a, nan_b, snan_a, snan_b;
      logic           a_lt_b;
      logic [FpW-1:0] qnan, minmax_res, res;

      assign {sign_a, mag_a} = operand_a_i[FpW-1:0];
      assign {sign_b, mag_b} = operand_b_i[FpW-1:0];

      // All-ones exponent with nonzero mantissa, quiet bit is the mantissa MSB
      assign nan_a  = (&mag_a[ManW +: ExpW]) & (|mag_a[ManW-1:0]);
      assign nan_b  = (&mag_b[ManW +: ExpW]) & (|mag_b[ManW-1:0]);
      assign snan_a = nan_a & ~mag_a[ManW-1];
      assign snan_b = nan_b & ~mag_b[ManW-1];
      assign qnan   = {1'b0, {ExpW{1'b1}}, 1'b1, {(ManW-1){1'b0}}};

      always_comb begin : sign_select
        unique case (op_i)
          fp_slice_pkg::SGNJN: sign_inj = ~sign_b;
          fp_slice_pkg::SGNJX: sign_inj = sign_a ^ sign_b;
          default:             sign_inj = sign_b;
        endcase
      end

      // Sign-magnitude order, -0 sorts below +0
      assign a_lt_b = (sign_a != sign_b) ? sign_a :
                      sign_a ? (mag_a > mag_b) : (mag_a < mag_b);

      always_comb begin : minmax
        if (nan_a && nan_b) begin
          minmax_res = qnan;
        end else if (nan_a) begin
          minmax_res = operand_b_i[FpW-1:0];
        end else if (nan_b) begin
          minmax_res = operand_a_i[FpW-1:0];
        end else if (a_lt_b ^ op_mod_i) begin
          minmax_res = operand_a_i[FpW-1:0];
        end else begin
          minmax_res = operand_b_i[FpW-1:0];
        end
      end

      assign res = (op_i == fp_slice_pkg::MINMAX) ? minmax_res : {sign_inj, mag_a};
      assign fmt_result[f] = LaneWidth'(res);
      assign fmt_status[f] = {(op_i == fp_slice_pkg::MINMAX) & (snan_a | snan_b), 4'b0000};
    end else begin : gen_inactive
      assign fmt_result[f] = '0;
      assign fmt_status[f] = '0;
    end
  end

  assign op_result = fmt_result[fmt_i];
  assign op_status = fmt_status[fmt_i];

  fp_lane_pipeline #(
    .NumPipeRegs ( NumPipeRegs ),
    .DataWidth   ( LaneWidth   )
  ) i_fp_lane_pipeline (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .result_i    ( op_result   ),
    .status_i    ( op_status   ),
    .mask_i      ( mask_i      ),
    .tag_i       ( tag_i       ),
    .aux_i       ( aux_i       ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .mask_o      ( mask_o      ),
    .tag_o       ( tag_o       ),
    .aux_o       ( aux_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  // The top must only hand this lane formats it was built for
  a_fmt_supported: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i |-> LaneFormats[fmt_i])
    else $error("Lane received an unsupported format");

endmodule

//--- source/fp_result_packer.sv
// ------------------
// Packs lane results per format and NaN-boxes unused slots with ones
// Status only collects lanes that are both valid and unmasked
// ------------------
`timescale 1ns/1ps

module fp_result_packer (
  input  logic [fp_slice_pkg::NUM_LANES-1:0][fp_slice_pkg::FLEN-1:0] lane_results_i,
  input  logic [fp_slice_pkg::NUM_LANES-1:0]                         lane_valid_i,
  input  fp_slice_pkg::status_t [fp_slice_pkg::NUM_LANES-1:0]        lane_status_i,
  input  logic [fp_slice_pkg::NUM_LANES-1:0]                         lane_mask_i,
  input  fp_slice_pkg::fp_format_e                                   fmt_i,
  output logic [fp_slice_pkg::FLEN-1:0]                              result_o,
  output fp_slice_pkg::status_t                                      status_o
);

  logic [fp_slice_pkg::NUM_FORMATS-1:0][fp_slice_pkg::FLEN-1:0] fmt_result;

  // --------------------
  // Slot assembly
  // --------------------
  for (genvar f = 0; f < fp_slice_pkg::NUM_FORMATS; f++) begin : gen_fmt
    localparam int unsigned FpW = fp_slice_pkg::fp_width(fp_slice_pkg::fp_format_e'(f));

    for (genvar l = 0; l < fp_slice_pkg::NUM_LANES; l++) begin : gen_slot
      localparam fp_slice_pkg::fmt_mask_t LaneFmts = fp_slice_pkg::lane_formats(l);

      if ((l + 1) * FpW <= fp_slice_pkg::FLEN) begin : gen_fits
        assign fmt_result[f][l*FpW +: FpW] = (lane_valid_i[l] && LaneFmts[f]) ?
                                             lane_results_i[l][FpW-1:0] : '1;
      end
    end
  end

  always_comb begin : select_result
    if (fmt_i inside {fp_slice_pkg::FP32, fp_slice_pkg::FP16, fp_slice_pkg::FP8}) begin
      result_o = fmt_result[fmt_i];
    end else begin
      result_o = '1;  // Boxed pattern for an illegal format
    end
  end

  // --------------------
  // Status collapse
  // --------------------
  always_comb begin : collapse_status
    status_o = '0;
    for (int unsigned l = 0; l < fp_slice_pkg::NUM_LANES; l++) begin
      status_o |= lane_status_i[l] & {5{lane_valid_i[l] & lane_mask_i[l]}};
    end
  end

  // Format travels through lane 0's aux, checked when that lane presents an item
  a_fmt_legal: assert final (!lane_valid_i[0] ||
    (fmt_i inside {fp_slice_pkg::FP32, fp_slice_pkg::FP16, fp_slice_pkg::FP8}))
    else $error("Packed result with illegal format encoding");

endmodule

//--- source/fp_multifmt_slice.sv
// ------------------
// Multi-format SIMD slice for sign injection and min/max
// Operands are used as given, no NaN-box check on inputs
// Upper lanes only run vector ops in FP16 or FP8
// ------------------
`timescale 1ns/1ps

module fp_multifmt_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [1:0][fp_slice_pkg::FLEN-1:0]    operands_i,
  input  fp_slice_pkg::operation_e              op_i,
  input  logic                                  op_mod_i,
  input  fp_slice_pkg::fp_format_e              fmt_i,
  input  logic                                  vectorial_op_i,
  input  fp_slice_pkg::tag_t                    tag_i,
  input  logic [fp_slice_pkg::NUM_LANES-1:0]    simd_mask_i,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  output logic [fp_slice_pkg::FLEN-1:0]         result_o,
  output fp_slice_pkg::status_t                 status_o,
  output fp_slice_pkg::tag_t                    tag_o,
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  output logic                                  busy_o
);

  localparam int unsigned NumLanes = fp_slice_pkg::NUM_LANES;

  logic [NumLanes-1:0] lane_valid, lane_ready;
  logic [NumLanes-1:0] lane_in_ready, lane_out_valid, lane_mask, lane_busy;
  logic [NumLanes-1:0][fp_slice_pkg::FLEN-1:0] lane_result;
  fp_slice_pkg::status_t [NumLanes-1:0] lane_status;
  fp_slice_pkg::tag_t [NumLanes-1:0]    lane_tag;
  fp_slice_pkg::aux_t [NumLanes-1:0]    lane_aux;
  fp_slice_pkg::aux_t       aux_data;
  logic                     result_is_vector;
  fp_slice_pkg::fp_format_e result_fmt;

  assign aux_data         = {vectorial_op_i, fmt_i};
  assign result_is_vector = lane_aux[0][2];
  assign result_fmt       = fp_slice_pkg::fp_format_e'(lane_aux[0][1:0]);

  // --------------------
  // Lanes
  // --------------------
  for (genvar lane = 0; lane < NumLanes; lane++) begin : gen_lanes
    localparam fp_slice_pkg::fmt_mask_t LaneFmts = fp_slice_pkg::lane_formats(lane);
    localparam int unsigned LaneW = fp_slice_pkg::lane_width(LaneFmts);

    logic [fp_slice_pkg::FLEN-1:0] shift_a, shift_b;
    logic [LaneW-1:0]              lane_res;
    logic                          out_valid;

    // Slot of this lane within the operand word
    assign shift_a = operands_i[0] >> (lane * fp_slice_pkg::fp_width(fmt_i));
    assign shift_b = operands_i[1] >> (lane * fp_slice_pkg::fp_width(fmt_i));

    // Upper lanes only take an item when lane 0 takes it too
    assign lane_valid[lane] = in_valid_i & LaneFmts[fmt_i] &
                              ((lane == 0) | (vectorial_op_i & lane_in_ready[0]));
    assign lane_ready[lane] = out_ready_i & ((lane == 0) | result_is_vector);

    fp_noncomp_lane #(
      .LaneFormats ( LaneFmts    ),
      .NumPipeRegs ( NumPipeRegs )
    ) i_fp_noncomp_lane (
      .clk_i       ( clk_i               ),
      .reset_i     ( reset_i             ),
      .operand_a_i ( shift_a[LaneW-1:0]  ),
      .operand_b_i ( shift_b[LaneW-1:0]  ),
      .op_i        ( op_i                ),
      .op_mod_i    ( op_mod_i            ),
      .fmt_i       ( fmt_i               ),
      .mask_i      ( simd_mask_i[lane]   ),
      .tag_i       ( tag_i               ),
      .aux_i       ( aux_data            ),
      .in_valid_i  ( lane_valid[lane]    ),
      .in_ready_o  ( lane_in_ready[lane] ),
      .result_o    ( lane_res            ),
      .status_o    ( lane_status[lane]   ),
      .mask_o      ( lane_mask[lane]     ),
      .tag_o       ( lane_tag[lane]      ),
      .aux_o       ( lane_aux[lane]      ),
      .out_valid_o ( out_valid           ),
      .out_ready_i ( lane_ready[lane]    ),
      .busy_o      ( lane_busy[lane]     )
    );

    assign lane_out_valid[lane] = out_valid & ((lane == 0) | result_is_vector);
    assign lane_result[lane]    = fp_slice_pkg::FLEN'(lane_res);
  end

  // --------------------
  // Output side
  // --------------------
  fp_result_packer i_fp_result_packer (
    .lane_results_i ( lane_result    ),
    .lane_valid_i   ( lane_out_valid ),
    .lane_status_i  ( lane_status    ),
    .lane_mask_i    ( lane_mask      ),
    .fmt_i          ( result_fmt     ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       )
  );

  assign in_ready_o  = lane_in_ready[0];   // Lane 0 speaks for the slice
  assign out_valid_o = lane_out_valid[0];
  assign tag_o       = lane_tag[0];
  assign busy_o      = |lane_busy;

  // Every lane taking part must accept whenever lane 0 does
  a_lanes_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i && in_ready_o |-> &(lane_in_ready | ~lane_valid))
    else $error("Upper lane not ready while lane 0 accepts");

endmodule

//--- verif/tb_ref_model.svh
// --------------------
// Reference model of the slice, included inside the testbench module
// Expected values follow the sign injection, min/max and packing rules
// --------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  // 16-bit Fibonacci LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic void fmt_geometry(input fp_slice_pkg::fp_format_e fmt,
                                       output int w, output int e, output int m);
    w = (fmt == fp_slice_pkg::FP32) ? 32 : (fmt == fp_slice_pkg::FP16) ? 16 : 8;
    e = (fmt == fp_slice_pkg::FP32) ? 8 : 5;
    m = w - e - 1;  // Hidden bit not stored
  endfunction

  function automatic logic [31:0] ref_lane_op(input fp_slice_pkg::operation_e op,
      input logic max_sel, input fp_slice_pkg::fp_format_e fmt,
      input logic [31:0] a_in, input logic [31:0] b_in, output logic nv);
    int w, e, m;
    logic [31:0] keep, a, b, exp_all, sign_bit, key_a, key_b;
    logic a_nan, b_nan, a_snan, b_snan, sign;
    fmt_geometry(fmt, w, e, m);
    keep     = 32'((33'd1 << w) - 33'd1);
    a        = a_in & keep;
    b        = b_in & keep;
    sign_bit = 32'd1 << (w - 1);
    exp_all  = ((32'd1 << e) - 1) << m;  // Exponent field all ones
    a_nan    = ((a & exp_all) == exp_all) && ((a & ((32'd1 << m) - 1)) != 0);
    b_nan    = ((b & exp_all) == exp_all) && ((b & ((32'd1 << m) - 1)) != 0);
    a_snan   = a_nan && !a[m - 1];
    b_snan   = b_nan && !b[m - 1];
    nv       = 1'b0;
    if (op != fp_slice_pkg::MINMAX) begin
      case (op)
        fp_slice_pkg::SGNJN: sign = !b[w - 1];
        fp_slice_pkg::SGNJX: sign = a[w - 1] ^ b[w - 1];
        default:             sign = b[w - 1];
      endcase
      return (a & ~sign_bit) | (sign ? sign_bit : 32'd0);
    end
    nv = a_snan || b_snan;
    if (a_nan && b_nan) return exp_all | (32'd1 << (m - 1));  // Canonical quiet NaN
    if (a_nan) return b;
    if (b_nan) return a;
    // Sign-magnitude mapped onto unsigned order, -0 just below +0
    key_a = a[w - 1] ? (~a & keep) : (a | sign_bit);
    key_b = b[w - 1] ? (~b & keep) : (b | sign_bit);
    if (max_sel) return (key_a >= key_b) ? a : b;
    return (key_a <= key_b) ? a : b;
  endfunction

  function automatic logic [31:0] ref_packed(input fp_slice_pkg::operation_e op,
      input logic max_sel, input fp_slice_pkg::fp_format_e fmt, input logic vec,
      input logic [3:0] mask, input logic [31:0] a, input logic [31:0] b,
      output fp_slice_pkg::status_t st);
    int w, e, m;
    logic [31:0] res, slot, keep;
    logic nv_slot, nv_all;
    fmt_geometry(fmt, w, e, m);
    keep   = 32'((33'd1 << w) - 33'd1);
    res    = '1;  // Unused slots stay boxed
    nv_all = 1'b0;
    for (int i = 0; i < (vec ? 32 / w : 1); i++) begin
      slot = ref_lane_op(op, max_sel, fmt, a >> (i * w), b >> (i * w), nv_slot);
      res  = (res & ~(keep << (i * w))) | (slot << (i * w));
      if (mask[i]) nv_all = nv_all | nv_slot;
    end
    st = {nv_all, 4'b0000};
    return res;
  endfunction

`endif

//--- verif/tb_fp_multifmt_slice.sv
// --------------------
// Testbench of the SIMD slice, built with NumPipeRegs of 2
// Vector ops under back-pressure are FP8 only, so all four lanes take part
// --------------------
`timescale 1ns/1ps

module tb_fp_multifmt_slice;

  localparam int NUM_DIRECTED = 40;   // Upper bound of the directed part
  localparam int NUM_RANDOM   = 200;
  localparam int PIPE_DEPTH   = 2;
  localparam int CLK_PERIOD   = 8;    // ns

  logic                     clk_i;
  logic                     reset_i;
  logic [1:0][31:0]         operands_i;
  fp_slice_pkg::operation_e op_i;
  logic                     op_mod_i;
  fp_slice_pkg::fp_format_e fmt_i;
  logic                     vectorial_op_i;
  fp_slice_pkg::tag_t       tag_i;
  logic [3:0]               simd_mask_i;
  logic                     in_valid_i;
  logic                     in_ready_o;
  logic [31:0]              result_o;
  fp_slice_pkg::status_t    status_o;
  fp_slice_pkg::tag_t       tag_o;
  logic                     out_valid_o;
  logic                     out_ready_i;
  logic                     busy_o;

  logic [15:0]           lfsr_state;
  logic [31:0]           exp_result_q[$];
  fp_slice_pkg::status_t exp_status_q[$];
  fp_slice_pkg::tag_t    exp_tag_q[$];
  int unsigned           exp_cycle_q[$];
  int unsigned           cycle_cnt, sent_cnt, accepted_cnt, received_cnt;
  bit                    check_latency, stall_mode;

  `include "tb_ref_model.svh"

  fp_multifmt_slice #(
    .NumPipeRegs ( PIPE_DEPTH )
  ) i_fp_multifmt_slice (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .operands_i     ( operands_i     ),
    .op_i           ( op_i           ),
    .op_mod_i       ( op_mod_i       ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .tag_i          ( tag_i          ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // --------------------
  // Helpers
  // --------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Half of the draws land on NaN, sNaN, zero or infinity
  function automatic logic [31:0] random_fp(input fp_slice_pkg::fp_format_e fmt);
    int w, e, m;
    logic [31:0] exp_all, payload, val;
    logic [2:0] kind;
    fmt_geometry(fmt, w, e, m);
    exp_all = ((32'd1 << e) - 1) << m;
    kind    = rand_bits(3);
    payload = rand_bits(m - 1);
    case (kind)
      3'd0:    val = exp_all | (32'd1 << (m - 1)) | payload;
      3'd1:    val = exp_all | ((payload == 0) ? 32'd1 : payload);  // Quiet bit clear
      3'd2:    val = 32'd0;
      3'd3:    val = exp_all;
      default: return rand_bits(w);
    endcase
    return val | (rand_bits(1) << (w - 1));
  endfunction

  function automatic logic [31:0] random_word(input fp_slice_pkg::fp_format_e fmt);
    int w, e, m;
    logic [31:0] word;
    fmt_geometry(fmt, w, e, m);
    word = '0;
    for (int i = 0; i < 32 / w; i++) begin
      word = word | (random_fp(fmt) << (i * w));
    end
    return word;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    out_ready_i = stall_mode ? (rand_bits(2) != 0) : 1'b1;
  endtask

  task automatic send(input fp_slice_pkg::operation_e op, input logic max_sel,
                      input fp_slice_pkg::fp_format_e fmt, input logic vec,
                      input logic [3:0] mask, input logic [31:0] a, input logic [31:0] b);
    bit taken;
    op_i           = op;
    op_mod_i       = max_sel;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    operands_i[0]  = a;
    operands_i[1]  = b;
    tag_i          = fp_slice_pkg::tag_t'(sent_cnt);
    in_valid_i     = 1'b1;
    sent_cnt++;
    do begin
      @(negedge clk_i);
      taken = in_ready_o;
      next_cycle();
    end while (!taken);
    in_valid_i = 1'b0;
  endtask

  task automatic send_minmax_pair(input fp_slice_pkg::fp_format_e fmt, input logic vec,
                                  input logic [3:0] mask, input logic [31:0] a,
                                  input logic [31:0] b);
    send(fp_slice_pkg::MINMAX, 1'b0, fmt, vec, mask, a, b);
    send(fp_slice_pkg::MINMAX, 1'b1, fmt, vec, mask, a, b);
  endtask

  // --------------------
  // Scoreboard
  // --------------------
  always @(negedge clk_i) begin : input_monitor
    logic [31:0] res;
    fp_slice_pkg::status_t st;
    if (!reset_i && in_valid_i && in_ready_o) begin
      res = ref_packed(op_i, op_mod_i, fmt_i, vectorial_op_i, simd_mask_i,
                       operands_i[0], operands_i[1], st);
      exp_result_q.push_back(res);
      exp_status_q.push_back(st);
      exp_tag_q.push_back(tag_i);
      exp_cycle_q.push_back(cycle_cnt);
      accepted_cnt++;
    end
  end

  always @(negedge clk_i) begin : compare_outputs
    logic [31:0] exp_res;
    fp_slice_pkg::status_t exp_st;
    fp_slice_pkg::tag_t exp_tag;
    int unsigned in_cycle;
    if (!reset_i && out_valid_o) begin
      check_value("busy_o", busy_o, 1'b1);  // An item at the output is still held
    end
    if (!reset_i && out_valid_o && out_ready_i) begin
      if (exp_result_q.size() == 0) begin
        report_failure("An output arrived with no input waiting for it");
      end else begin
        exp_res  = exp_result_q.pop_front();
        exp_st   = exp_status_q.pop_front();
        exp_tag  = exp_tag_q.pop_front();
        in_cycle = exp_cycle_q.pop_front();
        check_value("result_o", result_o, exp_res);
        check_value("status_o", status_o, exp_st);
        check_value("tag_o", tag_o, exp_tag);
        if (check_latency) check_value("latency", cycle_cnt - in_cycle, PIPE_DEPTH);
        received_cnt++;
      end
    end
  end

  initial begin : watchdog
    #((NUM_DIRECTED + NUM_RANDOM) * 40 * CLK_PERIOD + 100 * CLK_PERIOD);
    report_failure("Timeout, the slice stopped accepting or returning transactions");
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : main
    fp_slice_pkg::operation_e op;
    fp_slice_pkg::fp_format_e fmt;
    logic vec, max_sel;
    logic [3:0] mask;
    logic [31:0] a, b;
    lfsr_state     = 16'd41914;
    cycle_cnt      = 0;
    sent_cnt       = 0;
    accepted_cnt   = 0;
    received_cnt   = 0;
    check_latency  = 1'b1;
    stall_mode     = 1'b0;
    reset_i        = 1'b1;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    operands_i     = '0;
    op_i           = fp_slice_pkg::SGNJ;
    op_mod_i       = 1'b0;
    fmt_i          = fp_slice_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("out_valid_o", out_valid_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("in_ready_o", in_ready_o, 1'b1);
    next_cycle();

    // Scalar sign injection in every format, then all ops as FP16 and FP8 vectors
    for (int f = 0; f < 3; f++) begin
      for (int o = 0; o < 3; o++) begin
        send(fp_slice_pkg::operation_e'(o), 1'b0, fp_slice_pkg::fp_format_e'(f), 1'b0,
             4'b0001, 32'hC1A0_5A3C, 32'h40D0_A5C3);
      end
    end
    for (int f = 1; f < 3; f++) begin
      for (int o = 0; o < 5; o++) begin
        send(fp_slice_pkg::operation_e'((o < 4) ? o : 3), (o == 4),
             fp_slice_pkg::fp_format_e'(f), 1'b1, 4'b1111, 32'hBC01_7E44, 32'h3C02_FD81);
      end
    end

    // Min/max ordering and NaN handling
    send_minmax_pair(fp_slice_pkg::FP32, 1'b0, 4'b0001, 32'h0000_0000, 32'h8000_0000);
    send_minmax_pair(fp_slice_pkg::FP32, 1'b0, 4'b0001, 32'h3F80_0000, 32'hC000_0000);
    send_minmax_pair(fp_slice_pkg::FP32, 1'b0, 4'b0001, 32'h7FC0_0001, 32'h3F80_0000);
    send_minmax_pair(fp_slice_pkg::FP32, 1'b0, 4'b0001, 32'h3F80_0000, 32'h7F80_0001);
    send_minmax_pair(fp_slice_pkg::FP32, 1'b0, 4'b0001, 32'h7FC0_0000, 32'h7F80_0005);
    send_minmax_pair(fp_slice_pkg::FP32, 1'b0, 4'b0001, 32'hFF80_0000, 32'h7F80_0000);
    send_minmax_pair(fp_slice_pkg::FP16, 1'b0, 4'b0001, 32'hFFFF_7C01, 32'hFFFF_3C00);
    // sNaN in a masked-off slot must not raise NV
    send(fp_slice_pkg::MINMAX, 1'b0, fp_slice_pkg::FP16, 1'b1, 4'b0001,
         32'h7C01_3C00, 32'hBC00_0000);
    send(fp_slice_pkg::MINMAX, 1'b0, fp_slice_pkg::FP16, 1'b1, 4'b0011,
         32'h7C01_3C00, 32'hBC00_0000);
    send(fp_slice_pkg::MINMAX, 1'b0, fp_slice_pkg::FP8, 1'b1, 4'b0111,
         32'h7D3C_807E, 32'h3CC0_007F);
    send(fp_slice_pkg::MINMAX, 1'b0, fp_slice_pkg::FP8, 1'b1, 4'b1111,
         32'h7D3C_807E, 32'h3CC0_007F);
    while (received_cnt != accepted_cnt) next_cycle();

    // Random traffic with idle gaps and random output stalls
    check_latency = 1'b0;
    stall_mode    = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      if (rand_bits(3) == 0) next_cycle();
      op      = fp_slice_pkg::operation_e'(rand_bits(2));
      max_sel = rand_bits(1);
      vec     = rand_bits(1);
      case (rand_bits(2))
        0:       fmt = fp_slice_pkg::FP32;
        1:       fmt = fp_slice_pkg::FP16;
        default: fmt = fp_slice_pkg::FP8;
      endcase
      if (vec) fmt = fp_slice_pkg::FP8;
      mask = rand_bits(4);
      a    = random_word(fmt);
      b    = random_word(fmt);
      send(op, max_sel, fmt, vec, mask, a, b);
    end
    while (received_cnt != accepted_cnt) next_cycle();
    stall_mode = 1'b0;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);

    if (received_cnt != sent_cnt) begin
      report_failure("Not every sent transaction came back from the slice");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- fp_multifmt_slice.f
+incdir+verif
source/fp_slice_pkg.sv
source/fp_lane_pipeline.sv
source/fp_noncomp_lane.sv
source/fp_result_packer.sv
source/fp_multifmt_slice.sv
verif/tb_fp_multifmt_slice.sv

//--- Bender.yml
package:
  name: fp_multifmt_slice

sources:
  - files:
      - source/fp_slice_pkg.sv
      - source/fp_lane_pipeline.sv
      - source/fp_noncomp_lane.sv
      - source/fp_result_packer.sv
      - source/fp_multifmt_slice.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_fp_multifmt_slice.sv
